/* ps2_params.svh */
`ifndef PS2_PARAMS_SVH
`define PS2_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Line timing, in system clocks
////////////////////////////////////////////////////////////////////////////

// Deglitch window, half high and half low for a valid edge
`define PS2_FILT_LEN 8

// Clocks without a falling device clock edge before a path gives up
`define PS2_TIMEOUT 4096

// Host clock inhibit ahead of a request to send
`define PS2_INHIBIT 400

////////////////////////////////////////////////////////////////////////////
// APB register byte addresses
////////////////////////////////////////////////////////////////////////////

`define PS2_ADDR_STATUS 4'h0
`define PS2_ADDR_RXDATA 4'h4
`define PS2_ADDR_TXDATA 4'h8
`define PS2_ADDR_CTRL   4'hC

`endif

/* ps2_proto_pkg.sv */
package ps2_proto_pkg;

    // Device-to-host frame receiver
    typedef enum logic [1:0] {
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

    // Host-to-device request sequence
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_INHIBIT,
        TX_REQUEST,
        TX_DATA,
        TX_PARITY,
        TX_RELEASE,
        TX_ACK
    } tx_state_t;

    // Keyboard scancode prefixes
    localparam logic [7:0] PS2_PREFIX_EXT   = 8'hE0;
    localparam logic [7:0] PS2_PREFIX_BREAK = 8'hF0;

endpackage

/* ps2_regs_pkg.sv */
package ps2_regs_pkg;

    // Address decode result
    typedef enum logic [2:0] {
        REG_STATUS,
        REG_RXDATA,
        REG_TXDATA,
        REG_CTRL,
        REG_NONE
    } reg_sel_t;

    // STATUS register bit positions
    localparam int STAT_RX_VALID = 0;
    localparam int STAT_EXTENDED = 1;
    localparam int STAT_RELEASED = 2;
    localparam int STAT_OVERRUN  = 3;
    localparam int STAT_TX_BUSY  = 4;
    localparam int STAT_TX_ERROR = 5;

endpackage

/* ps2_line_filter.sv */
`timescale 1ns/1ps
`include "ps2_params.svh"

module ps2_line_filter (
    input  logic clk,
    input  logic rst,
    input  logic ps2_clk,
    input  logic ps2_data,
    output logic ps2_clk_fall,
    output logic ps2_clk_rise,
    output logic data_level
);

    localparam int LEN = `PS2_FILT_LEN;

    // Older samples sit in the upper half of the window
    localparam logic [LEN-1:0] FALL_PAT = {{(LEN/2){1'b1}}, {(LEN/2){1'b0}}};
    localparam logic [LEN-1:0] RISE_PAT = ~FALL_PAT;

    logic [1:0]     clk_sync;
    logic [1:0]     data_sync;
    logic [LEN-1:0] clk_win;

    // Idle lines are pulled high, so start from all ones
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_win   <= '1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_win   <= {clk_win[LEN-2:0], clk_sync[1]};
        end
    end

    // An edge counts only on a clean half-and-half window
    assign ps2_clk_fall = (clk_win == FALL_PAT);
    assign ps2_clk_rise = (clk_win == RISE_PAT);
    assign data_level   = data_sync[1];

endmodule

/* ps2_rx.sv */
`timescale 1ns/1ps
`include "ps2_params.svh"

module ps2_rx
    import ps2_proto_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rx_enable,
    input  logic       mouse_mode,
    input  logic       ps2_clk_fall,
    input  logic       data_level,
    output logic       rx_strobe,
    output logic [7:0] rx_byte,
    output logic       rx_extended,
    output logic       rx_released
);

    localparam int TMO_W = $clog2(`PS2_TIMEOUT);

    rx_state_t        state;
    logic [7:0]       shift;
    logic [TMO_W-1:0] tmo_cnt;
    logic             ext_pend;
    logic             brk_pend;
    logic             is_ext;
    logic             is_brk;

    // Prefixes only mean something to a keyboard
    assign is_ext = !mouse_mode && (shift == PS2_PREFIX_EXT);
    assign is_brk = !mouse_mode && (shift == PS2_PREFIX_BREAK);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= RX_START;
            tmo_cnt   <= '0;
            ext_pend  <= 1'b0;
            brk_pend  <= 1'b0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            if (!rx_enable) begin
                state    <= RX_START;
                tmo_cnt  <= '0;
                ext_pend <= 1'b0;
                brk_pend <= 1'b0;
            end else if (ps2_clk_fall) begin
                tmo_cnt <= '0;
                case (state)
                    RX_START: begin
                        if (!data_level) begin
                            state <= RX_DATA;
                            // Marker bit reaches bit 0 after seven shifts
                            shift <= 8'h80;
                        end
                    end
                    RX_DATA: begin
                        shift <= {data_level, shift[7:1]};
                        if (shift[0]) begin
                            state <= RX_PARITY;
                        end
                    end
                    RX_PARITY: begin
                        // Odd parity over data and parity bit
                        state <= (^{shift, data_level}) ? RX_STOP : RX_START;
                    end
                    RX_STOP: begin
                        state <= RX_START;
                        if (data_level) begin
                            if (is_ext) begin
                                ext_pend <= 1'b1;
                            end else if (is_brk) begin
                                brk_pend <= 1'b1;
                            end else begin
                                rx_strobe   <= 1'b1;
                                rx_byte     <= shift;
                                rx_extended <= ext_pend && !mouse_mode;
                                rx_released <= brk_pend && !mouse_mode;
                                ext_pend    <= 1'b0;
                                brk_pend    <= 1'b0;
                            end
                        end
                    end
                    default: state <= RX_START;
                endcase
            end else if (state != RX_START) begin
                // Stalled frame, drop it along with any prefix
                if (tmo_cnt == TMO_W'(`PS2_TIMEOUT - 1)) begin
                    state    <= RX_START;
                    tmo_cnt  <= '0;
                    ext_pend <= 1'b0;
                    brk_pend <= 1'b0;
                end else begin
                    tmo_cnt <= tmo_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* ps2_tx.sv */
`timescale 1ns/1ps
`include "ps2_params.svh"

module ps2_tx
    import ps2_proto_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    input  logic       ps2_clk_fall,
    input  logic       ps2_clk_rise,
    input  logic       data_level,
    output logic       ps2_clk_low,
    output logic       ps2_data_low,
    output logic       tx_busy,
    output logic       tx_error
);

    // One counter serves the inhibit time and the edge timeout
    localparam int CNT_W = $clog2(`PS2_TIMEOUT + `PS2_INHIBIT);

    tx_state_t        state;
    logic [7:0]       shift;
    logic             parity_bit;
    logic [2:0]       bit_cnt;
    logic [CNT_W-1:0] cnt;
    logic             inhibit_done;
    logic             timed_out;

    assign inhibit_done = (cnt == CNT_W'(`PS2_INHIBIT - 1));
    assign timed_out    = (cnt == CNT_W'(`PS2_TIMEOUT - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Request sequence
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= TX_IDLE;
            cnt      <= '0;
            bit_cnt  <= '0;
            tx_error <= 1'b0;
        end else if (state == TX_IDLE) begin
            cnt <= '0;
            if (tx_start) begin
                shift      <= tx_byte;
                parity_bit <= ~^tx_byte;
                tx_error   <= 1'b0;
                state      <= TX_INHIBIT;
            end
        end else if (state == TX_INHIBIT) begin
            if (inhibit_done) begin
                cnt   <= '0;
                state <= TX_REQUEST;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end else if (state == TX_ACK && ps2_clk_rise) begin
            // Device has let go of the clock after the acknowledge
            state <= TX_IDLE;
        end else if (ps2_clk_fall) begin
            cnt <= '0;
            case (state)
                TX_REQUEST: begin
                    state   <= TX_DATA;
                    bit_cnt <= '0;
                end
                TX_DATA: begin
                    shift   <= {1'b1, shift[7:1]};
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) begin
                        state <= TX_PARITY;
                    end
                end
                TX_PARITY:  state <= TX_RELEASE;
                TX_RELEASE: begin
                    // Device pulls data low to acknowledge
                    tx_error <= data_level;
                    state    <= TX_ACK;
                end
                default: ;
            endcase
        end else if (timed_out) begin
            tx_error <= 1'b1;
            state    <= TX_IDLE;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Open-drain drive enables
    ////////////////////////////////////////////////////////////////////////////

    assign ps2_clk_low  = (state == TX_INHIBIT);
    assign ps2_data_low = (state == TX_INHIBIT) || (state == TX_REQUEST)
                       || (state == TX_DATA && !shift[0])
                       || (state == TX_PARITY && !parity_bit);
    assign tx_busy      = (state != TX_IDLE);

endmodule

/* ps2_apb_regs.sv */
`timescale 1ns/1ps
`include "ps2_params.svh"

module ps2_apb_regs
    import ps2_regs_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    input  logic        rx_strobe,
    input  logic [7:0]  rx_byte,
    input  logic        rx_extended,
    input  logic        rx_released,
    input  logic        tx_busy,
    input  logic        tx_error,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        rx_enable,
    output logic        mouse_mode,
    output logic        tx_start,
    output logic [7:0]  tx_byte,
    output logic        irq
);

    // CTRL bit positions
    localparam int CTRL_RX_EN = 0;
    localparam int CTRL_MOUSE = 1;

    reg_sel_t    sel;
    logic        access;
    logic        rd_rxdata;
    logic        rd_status;
    logic        busy_now;
    logic        tx_reject;
    logic [1:0]  ctrl_q;
    logic [7:0]  rx_data_q;
    logic        rx_valid_q;
    logic        ext_q;
    logic        rel_q;
    logic        ovr_q;
    logic [31:0] status;

    always_comb begin
        case (paddr)
            `PS2_ADDR_STATUS: sel = REG_STATUS;
            `PS2_ADDR_RXDATA: sel = REG_RXDATA;
            `PS2_ADDR_TXDATA: sel = REG_TXDATA;
            `PS2_ADDR_CTRL:   sel = REG_CTRL;
            default:          sel = REG_NONE;
        endcase
    end

    assign access    = psel && penable;
    assign rd_rxdata = access && !pwrite && (sel == REG_RXDATA);
    assign rd_status = access && !pwrite && (sel == REG_STATUS);
    // A launch still in flight counts as busy
    assign busy_now  = tx_busy || tx_start;
    assign tx_reject = pwrite && (sel == REG_TXDATA) && busy_now;

    // Zero-wait slave
    assign pready  = 1'b1;
    assign pslverr = access && ((sel == REG_NONE) || tx_reject);

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q     <= '0;
            rx_valid_q <= 1'b0;
            ext_q      <= 1'b0;
            rel_q      <= 1'b0;
            ovr_q      <= 1'b0;
            tx_start   <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            if (access && pwrite && sel == REG_CTRL) begin
                ctrl_q <= pwdata[1:0];
            end
            if (access && pwrite && sel == REG_TXDATA && !busy_now) begin
                tx_start <= 1'b1;
                tx_byte  <= pwdata[7:0];
            end

            if (rd_status) begin
                ovr_q <= 1'b0;
            end
            // A new byte wins over a read in the same cycle
            if (rx_strobe) begin
                rx_data_q  <= rx_byte;
                ext_q      <= rx_extended;
                rel_q      <= rx_released;
                rx_valid_q <= 1'b1;
                if (rx_valid_q && !rd_rxdata) begin
                    ovr_q <= 1'b1;
                end
            end else if (rd_rxdata) begin
                rx_valid_q <= 1'b0;
                ext_q      <= 1'b0;
                rel_q      <= 1'b0;
            end
        end
    end

    always_comb begin
        status                = '0;
        status[STAT_RX_VALID] = rx_valid_q;
        status[STAT_EXTENDED] = ext_q;
        status[STAT_RELEASED] = rel_q;
        status[STAT_OVERRUN]  = ovr_q;
        status[STAT_TX_BUSY]  = tx_busy;
        status[STAT_TX_ERROR] = tx_error;
    end

    always_comb begin
        case (sel)
            REG_STATUS: prdata = status;
            REG_RXDATA: prdata = {24'b0, rx_data_q};
            REG_TXDATA: prdata = {24'b0, tx_byte};
            REG_CTRL:   prdata = {30'b0, ctrl_q};
            default:    prdata = '0;
        endcase
    end

    // Receiver stays quiet while the host owns the lines
    assign rx_enable  = ctrl_q[CTRL_RX_EN] && !tx_busy;
    assign mouse_mode = ctrl_q[CTRL_MOUSE];
    assign irq        = rx_valid_q;

endmodule

/* ps2_ctrl_top.sv */
`timescale 1ns/1ps

module ps2_ctrl_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        ps2_clk,
    input  logic        ps2_data,
    output logic        ps2_clk_low,
    output logic        ps2_data_low,
    output logic        irq
);

    logic       ps2_clk_fall;
    logic       ps2_clk_rise;
    logic       data_level;
    logic       rx_enable;
    logic       mouse_mode;
    logic       rx_strobe;
    logic [7:0] rx_byte;
    logic       rx_extended;
    logic       rx_released;
    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_busy;
    logic       tx_error;

    ps2_line_filter u_filter (
        .clk          (clk),
        .rst          (rst),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .ps2_clk_fall (ps2_clk_fall),
        .ps2_clk_rise (ps2_clk_rise),
        .data_level   (data_level)
    );

    ps2_rx u_rx (
        .clk          (clk),
        .rst          (rst),
        .rx_enable    (rx_enable),
        .mouse_mode   (mouse_mode),
        .ps2_clk_fall (ps2_clk_fall),
        .data_level   (data_level),
        .rx_strobe    (rx_strobe),
        .rx_byte      (rx_byte),
        .rx_extended  (rx_extended),
        .rx_released  (rx_released)
    );

    ps2_tx u_tx (
        .clk          (clk),
        .rst          (rst),
        .tx_start     (tx_start),
        .tx_byte      (tx_byte),
        .ps2_clk_fall (ps2_clk_fall),
        .ps2_clk_rise (ps2_clk_rise),
        .data_level   (data_level),
        .ps2_clk_low  (ps2_clk_low),
        .ps2_data_low (ps2_data_low),
        .tx_busy      (tx_busy),
        .tx_error     (tx_error)
    );

    ps2_apb_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .rx_strobe   (rx_strobe),
        .rx_byte     (rx_byte),
        .rx_extended (rx_extended),
        .rx_released (rx_released),
        .tx_busy     (tx_busy),
        .tx_error    (tx_error),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .rx_enable   (rx_enable),
        .mouse_mode  (mouse_mode),
        .tx_start    (tx_start),
        .tx_byte     (tx_byte),
        .irq         (irq)
    );

endmodule

/* ps2_dev_model.sv */
`timescale 1ns/1ps

module ps2_dev_model (
    input  logic       clk,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic       no_ack,
    output logic       clk_low,
    output logic       data_low,
    output logic [7:0] cap_byte,
    output logic       cap_parity,
    output logic       cap_stop,
    output int         cap_count
);

    // System clocks per device clock half period
    localparam int HALF = 40;

    logic active;

    initial begin
        clk_low    = 1'b0;
        data_low   = 1'b0;
        cap_byte   = 8'h00;
        cap_parity = 1'b0;
        cap_stop   = 1'b0;
        cap_count  = 0;
        active     = 1'b0;
    end

    // Line changes land just after the system clock edge
    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Device-to-host frame with data set in the middle of the high phase
    task automatic send_frame(input logic [7:0] value, input logic bad_parity);
        logic [10:0] frame;
        int          i;
        active = 1'b1;
        frame  = {1'b1, (~^value) ^ bad_parity, value, 1'b0};
        for (i = 0; i < 11; i++) begin
            data_low = !frame[i];
            wait_clocks(HALF / 2);
            clk_low = 1'b1;
            wait_clocks(HALF);
            clk_low = 1'b0;
            wait_clocks(HALF / 2);
        end
        data_low = 1'b0;
        wait_clocks(2 * HALF);
        active = 1'b0;
    endtask

    // Host-to-device frame sampled in the high phase after each rising edge
    task automatic accept_host_frame();
        logic [9:0] bits;
        int         i;
        active = 1'b1;
        wait_clocks(HALF);
        for (i = 0; i < 11; i++) begin
            clk_low = 1'b1;
            wait_clocks(HALF);
            clk_low = 1'b0;
            wait_clocks(HALF / 2);
            if (i < 10) begin
                bits[i] = ps2_data;
            end
            if (i == 9) begin
                cap_byte   = bits[7:0];
                cap_parity = bits[8];
                cap_stop   = bits[9];
                cap_count  = cap_count + 1;
                // Acknowledge bit for the last clock
                data_low   = !no_ack;
            end
            wait_clocks(HALF / 2);
        end
        data_low = 1'b0;
        wait_clocks(HALF);
        active = 1'b0;
    endtask

    // Request to send shows as a released clock with data still low
    always @(posedge clk) begin
        if (!active && ps2_clk === 1'b1 && ps2_data === 1'b0) begin
            accept_host_frame();
        end
    end

endmodule

/* tb_ps2_ctrl.sv */
`timescale 1ns/1ps
`include "ps2_params.svh"

module tb_ps2_ctrl
    import ps2_proto_pkg::*;
    import ps2_regs_pkg::*;
();

    localparam int   NUM_ROWS   = 10;
    localparam int   WAIT_LIMIT = 20000;
    localparam logic OP_DEVICE  = 1'b0;
    localparam logic OP_HOST    = 1'b1;

    typedef struct packed {
        logic        host_op;
        logic [1:0]  nbytes;
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [7:0]  b2;
        logic        bad_par;
        logic        mouse;
        logic        no_ack;
        logic [7:0]  exp_rx;
        logic [31:0] exp_stat;
        logic [7:0]  exp_cap;
    } row_t;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        ps2_clk;
    logic        ps2_data;
    logic        ps2_clk_low;
    logic        ps2_data_low;
    logic        irq;
    logic        dev_clk_low;
    logic        dev_data_low;
    logic        no_ack;
    logic [7:0]  cap_byte;
    logic        cap_parity;
    logic        cap_stop;
    int          cap_count;

    row_t        rows [NUM_ROWS];
    int          row_errs;
    int          tests;
    int          failures;
    int          k;
    logic [31:0] seed;

    ps2_ctrl_top uut (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .ps2_clk_low  (ps2_clk_low),
        .ps2_data_low (ps2_data_low),
        .irq          (irq)
    );

    ps2_dev_model dev (
        .clk        (clk),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .no_ack     (no_ack),
        .clk_low    (dev_clk_low),
        .data_low   (dev_data_low),
        .cap_byte   (cap_byte),
        .cap_parity (cap_parity),
        .cap_stop   (cap_stop),
        .cap_count  (cap_count)
    );

    // Wired-AND lines with pull-up
    assign ps2_clk  = !(ps2_clk_low || dev_clk_low);
    assign ps2_data = !(ps2_data_low || dev_data_low);

    always #4 clk = ~clk;

    initial begin
        #2_000_000;
        $display("Simulation watchdog expired before the test sequence ended");
        $display("SOME TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        row_errs++;
    endtask

    task automatic report_problem(input string what);
        $display("ERROR: %s", what);
        row_errs++;
    endtask

    task automatic close_test(input string label);
        tests++;
        if (row_errs == 0) begin
            $display("PASS %s", label);
        end else begin
            $display("FAIL %s (%0d errors)", label, row_errs);
            failures++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // APB master
    ////////////////////////////////////////////////////////////////////////////

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #2;
        err = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #2;
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_for_irq(output logic seen);
        int n;
        n = 0;
        while (!irq && n < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        seen = irq;
    endtask

    // Each STATUS read takes three clocks
    task automatic wait_tx_idle(output logic done, output logic [31:0] stat);
        int   n;
        logic err;
        n    = 0;
        done = 1'b0;
        stat = '0;
        while (!done && n < WAIT_LIMIT) begin
            apb_read(`PS2_ADDR_STATUS, stat, err);
            n = n + 3;
            if (!stat[STAT_TX_BUSY]) begin
                done = 1'b1;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] status_word(input logic valid, input logic ext,
                                                input logic rel, input logic ovr,
                                                input logic err);
        logic [31:0] w;
        w                = '0;
        w[STAT_RX_VALID] = valid;
        w[STAT_EXTENDED] = ext;
        w[STAT_RELEASED] = rel;
        w[STAT_OVERRUN]  = ovr;
        w[STAT_TX_ERROR] = err;
        return w;
    endfunction

    function automatic row_t make_row(
        input logic        host_op,
        input logic [1:0]  nbytes,
        input logic [7:0]  b0,
        input logic [7:0]  b1,
        input logic [7:0]  b2,
        input logic        bad_par,
        input logic        mouse,
        input logic        no_ack_flag,
        input logic [7:0]  exp_rx,
        input logic [31:0] exp_stat,
        input logic [7:0]  exp_cap
    );
        row_t r;
        r.host_op  = host_op;
        r.nbytes   = nbytes;
        r.b0       = b0;
        r.b1       = b1;
        r.b2       = b2;
        r.bad_par  = bad_par;
        r.mouse    = mouse;
        r.no_ack   = no_ack_flag;
        r.exp_rx   = exp_rx;
        r.exp_stat = exp_stat;
        r.exp_cap  = exp_cap;
        return r;
    endfunction

    // Keyboard byte that is not a prefix
    function automatic logic [7:0] pick_byte();
        logic [7:0] b;
        b = $urandom & 8'hFF;
        while (b == PS2_PREFIX_EXT || b == PS2_PREFIX_BREAK) begin
            b = $urandom & 8'hFF;
        end
        return b;
    endfunction

    task automatic load_table();
        logic [7:0] r0;
        logic [7:0] r1;
        r0 = pick_byte();
        r1 = pick_byte();
        rows[0] = make_row(OP_DEVICE, 2'd1, 8'h1C, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0,
                           8'h1C, status_word(1, 0, 0, 0, 0), 8'h00);
        rows[1] = make_row(OP_DEVICE, 2'd3, PS2_PREFIX_EXT, PS2_PREFIX_BREAK, 8'h74,
                           1'b0, 1'b0, 1'b0, 8'h74, status_word(1, 1, 1, 0, 0), 8'h00);
        rows[2] = make_row(OP_DEVICE, 2'd2, PS2_PREFIX_BREAK, 8'h1C, 8'h00, 1'b0, 1'b0,
                           1'b0, 8'h1C, status_word(1, 0, 1, 0, 0), 8'h00);
        rows[3] = make_row(OP_DEVICE, 2'd1, 8'h2A, 8'h00, 8'h00, 1'b1, 1'b0, 1'b0,
                           8'h00, status_word(0, 0, 0, 0, 0), 8'h00);
        rows[4] = make_row(OP_DEVICE, 2'd2, 8'h1C, 8'h32, 8'h00, 1'b0, 1'b0, 1'b0,
                           8'h32, status_word(1, 0, 0, 1, 0), 8'h00);
        rows[5] = make_row(OP_DEVICE, 2'd1, PS2_PREFIX_BREAK, 8'h00, 8'h00, 1'b0, 1'b1,
                           1'b0, PS2_PREFIX_BREAK, status_word(1, 0, 0, 0, 0), 8'h00);
        rows[6] = make_row(OP_DEVICE, 2'd1, r0, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0,
                           r0, status_word(1, 0, 0, 0, 0), 8'h00);
        rows[7] = make_row(OP_DEVICE, 2'd1, r1, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0,
                           r1, status_word(1, 0, 0, 0, 0), 8'h00);
        rows[8] = make_row(OP_HOST, 2'd1, 8'hA5, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0,
                           8'h00, status_word(0, 0, 0, 0, 0), 8'hA5);
        // Missing acknowledge goes last since TX_ERROR stays set afterwards
        rows[9] = make_row(OP_HOST, 2'd1, 8'h5A, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1,
                           8'h00, status_word(0, 0, 0, 0, 1), 8'h5A);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test steps
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        logic [31:0] rd;
        logic        err;
        apb_read(`PS2_ADDR_STATUS, rd, err);
        if (rd !== 32'h0) report_mismatch("STATUS", rd, 32'h0);
        apb_read(`PS2_ADDR_CTRL, rd, err);
        if (rd !== 32'h0) report_mismatch("CTRL", rd, 32'h0);
        if (irq !== 1'b0) report_mismatch("irq", irq, 0);
        if (ps2_clk_low !== 1'b0) report_mismatch("ps2_clk_low", ps2_clk_low, 0);
        if (ps2_data_low !== 1'b0) report_mismatch("ps2_data_low", ps2_data_low, 0);
        if (pready !== 1'b1) report_mismatch("pready", pready, 1);
        // Address between the mapped registers
        apb_read(4'h2, rd, err);
        if (err !== 1'b1) report_mismatch("pslverr", err, 1);
    endtask

    task automatic run_device_row(input row_t r);
        logic [31:0] rd;
        logic        err;
        logic        seen;
        apb_write(`PS2_ADDR_CTRL, {30'b0, r.mouse, 1'b1}, err);
        if (err !== 1'b0) report_mismatch("pslverr", err, 0);
        dev.send_frame(r.b0, r.bad_par);
        if (r.nbytes > 1) dev.send_frame(r.b1, r.bad_par);
        if (r.nbytes > 2) dev.send_frame(r.b2, r.bad_par);
        wait_for_irq(seen);
        if (r.exp_stat[STAT_RX_VALID]) begin
            if (!seen) report_problem("irq never rose for a received byte");
            apb_read(`PS2_ADDR_STATUS, rd, err);
            if (rd !== r.exp_stat) report_mismatch("STATUS", rd, r.exp_stat);
            apb_read(`PS2_ADDR_RXDATA, rd, err);
            if (rd !== {24'b0, r.exp_rx}) report_mismatch("RXDATA", rd, {24'b0, r.exp_rx});
            // Both reads above leave every receive flag clear
            apb_read(`PS2_ADDR_STATUS, rd, err);
            if (rd !== 32'h0) report_mismatch("STATUS", rd, 32'h0);
            if (irq !== 1'b0) report_mismatch("irq", irq, 0);
        end else begin
            if (seen) report_problem("irq rose for a frame that should have been dropped");
            apb_read(`PS2_ADDR_STATUS, rd, err);
            if (rd !== r.exp_stat) report_mismatch("STATUS", rd, r.exp_stat);
        end
    endtask

    task automatic run_host_row(input row_t r);
        logic [31:0] stat;
        logic        err;
        logic        done;
        logic        exp_par;
        int          start_count;
        start_count = cap_count;
        // Odd parity makes the count of ones over byte and parity odd
        exp_par = ($countones(r.exp_cap) % 2) == 0;
        apb_write(`PS2_ADDR_CTRL, 32'h1, err);
        apb_write(`PS2_ADDR_TXDATA, {24'b0, r.b0}, err);
        if (err !== 1'b0) report_mismatch("pslverr", err, 0);
        // Second write lands while the first is still in flight
        apb_write(`PS2_ADDR_TXDATA, {24'b0, ~r.b0}, err);
        if (err !== 1'b1) report_mismatch("pslverr", err, 1);
        wait_tx_idle(done, stat);
        if (!done) report_problem("transmitter stayed busy past the timeout");
        if (stat !== r.exp_stat) report_mismatch("STATUS", stat, r.exp_stat);
        if (cap_count != start_count + 1) begin
            report_problem("device model did not capture exactly one host frame");
        end
        if (cap_byte !== r.exp_cap) report_mismatch("cap_byte", cap_byte, r.exp_cap);
        if (cap_parity !== exp_par) report_mismatch("cap_parity", cap_parity, exp_par);
        if (cap_stop !== 1'b1) report_mismatch("cap_stop", cap_stop, 1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed     = $urandom(32'hc1cb_b683);
        clk      = 1'b0;
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = 4'h0;
        pwdata   = 32'h0;
        no_ack   = 1'b0;
        tests    = 0;
        failures = 0;
        load_table();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        row_errs = 0;
        check_reset_state();
        close_test("reset state");

        for (k = 0; k < NUM_ROWS; k++) begin
            row_errs = 0;
            no_ack   = rows[k].no_ack;
            if (rows[k].host_op) begin
                run_host_row(rows[k]);
            end else begin
                run_device_row(rows[k]);
            end
            close_test($sformatf("row %0d %s bytes %h %h %h", k,
                                 rows[k].host_op ? "host send" : "device send",
                                 rows[k].b0, rows[k].b1, rows[k].b2));
        end

        $display("%0d tests run, %0d passed, %0d failed", tests, tests - failures, failures);
        if (failures == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+.
ps2_proto_pkg.sv
ps2_regs_pkg.sv
ps2_line_filter.sv
ps2_rx.sv
ps2_tx.sv
ps2_apb_regs.sv
ps2_ctrl_top.sv
ps2_dev_model.sv
tb_ps2_ctrl.sv

/* Bender.yml */
package:
  name: ps2_ctrl

sources:
  - include_dirs:
      - .
    files:
      - ps2_proto_pkg.sv
      - ps2_regs_pkg.sv
      - ps2_line_filter.sv
      - ps2_rx.sv
      - ps2_tx.sv
      - ps2_apb_regs.sv
      - ps2_ctrl_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - ps2_dev_model.sv
      - tb_ps2_ctrl.sv
